// File: rtl/cpuSettings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Instruction memory size in 32-bit words
`define IMEM_DEPTH 256

// Data memory size in 32-bit words
`define DMEM_DEPTH 256

// paddr[15:REGION_LSB] picks the region
// paddr[REGION_LSB-1:2] is the word address inside it
`define REGION_LSB 12

`endif

// File: rtl/isaPkg.sv
package isaPkg;

	typedef enum logic [5:0] {
		OP_RTYPE = 6'b000000,
		OP_LI    = 6'b001001,
		OP_XORI  = 6'b001110,
		OP_LW    = 6'b100011,
		OP_SW    = 6'b101011
	} opcodeE;

	typedef enum logic [5:0] {
		FN_SYSCALL = 6'b001100,
		FN_ADD     = 6'b100000,
		FN_SUB     = 6'b100010,
		FN_SLT     = 6'b101010
	} funcE;

	// I-type immediate overlays rd, shamt and func
	typedef struct packed {
		opcodeE     opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		funcE       func;
	} instrT;

	function automatic logic isSyscall(input instrT i);
		return i.opcode == OP_RTYPE && i.func == FN_SYSCALL;
	endfunction

	function automatic logic writesReg(input instrT i);
		case (i.opcode)
			OP_RTYPE: return i.func inside {FN_ADD, FN_SUB, FN_SLT};
			OP_LI, OP_XORI, OP_LW: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	function automatic logic [4:0] destReg(input instrT i);
		return (i.opcode == OP_RTYPE) ? i.rd : i.rt;
	endfunction

	// rt is a source only for R-type and stores
	function automatic logic readsRt(input instrT i);
		return i.opcode == OP_RTYPE || i.opcode == OP_SW;
	endfunction

	function automatic logic [31:0] immOf(input instrT i);
		logic [31:0] raw;
		raw = i;
		return {{16{raw[15]}}, raw[15:0]};
	endfunction

endpackage

// File: rtl/pipePkg.sv
`include "cpuSettings.svh"

package pipePkg;

	import isaPkg::*;

	typedef struct packed {
		logic  valid;
		instrT instr;
	} ifIdT;

	typedef struct packed {
		logic        valid;
		instrT       instr;
		logic [31:0] opA;
		logic [31:0] opB;
	} idExT;

	typedef struct packed {
		logic        valid;
		instrT       instr;
		logic [31:0] aluResult;
		logic [31:0] storeData;
	} exMemT;

	// Register write port, also the older forwarding source
	typedef struct packed {
		logic        en;
		logic [4:0]  dest;
		logic [31:0] value;
	} wbT;

	typedef struct packed {
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [15:0] paddr;
		logic [31:0] pwdata;
	} apbReqT;

	typedef struct packed {
		logic [31:0] prdata;
		logic        pready;
		logic        pslverr;
	} apbRspT;

	typedef struct packed {
		logic                    en;
		logic                    wr;
		logic [`REGION_LSB-3:0]  addr;
		logic [31:0]             wdata;
	} hostAccessT;

	typedef enum logic [1:0] {
		IDLE    = 2'd0,
		RUNNING = 2'd1,
		HALTED  = 2'd2
	} runStateE;

endpackage

// File: rtl/hostPort.sv
`include "cpuSettings.svh"

module hostPort import pipePkg::*; (
	input  logic        clk,
	input  logic        rstN,
	input  apbReqT      apbReq,
	output apbRspT      apbRsp,
	output hostAccessT  imemAcc,
	output hostAccessT  dmemAcc,
	output hostAccessT  regAcc,
	input  logic [31:0] imemRdata,
	input  logic [31:0] dmemRdata,
	input  logic [31:0] regRdata,
	input  logic        sysRetire,
	output logic        runStart,
	output logic        running
);

	localparam int RW = 16 - `REGION_LSB;
	localparam logic [RW-1:0] REGION_IMEM = 'd0;
	localparam logic [RW-1:0] REGION_DMEM = 'd1;
	localparam logic [RW-1:0] REGION_REGS = 'd2;
	localparam logic [RW-1:0] REGION_CTRL = 'd3;

	runStateE state;
	runStateE statusQ;
	logic [RW-1:0] region;
	logic [RW-1:0] regionQ;
	logic setup;
	logic illegal;
	logic errQ;
	logic startWr;
	hostAccessT acc;

	assign setup = apbReq.psel && !apbReq.penable;
	assign region = apbReq.paddr[15:`REGION_LSB];
	assign startWr = setup && apbReq.pwrite && region == REGION_CTRL && apbReq.pwdata == 32'd1;
	assign runStart = startWr && state != RUNNING;
	assign running = state == RUNNING;

	always_comb begin
		case (region)
			REGION_IMEM, REGION_DMEM: illegal = running;
			REGION_REGS: illegal = apbReq.pwrite;
			REGION_CTRL: illegal = 1'b0;
			default: illegal = 1'b1;
		endcase
	end

	// Targets see the setup-phase address and answer one cycle later
	always_comb begin
		acc.en = 1'b0;
		acc.wr = apbReq.pwrite;
		acc.addr = apbReq.paddr[`REGION_LSB-1:2];
		acc.wdata = apbReq.pwdata;
		imemAcc = acc;
		dmemAcc = acc;
		regAcc = acc;
		imemAcc.en = setup && !illegal && region == REGION_IMEM;
		dmemAcc.en = setup && !illegal && region == REGION_DMEM;
		regAcc.en = setup && !illegal && region == REGION_REGS;
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE, HALTED: if (startWr) state <= RUNNING;
				RUNNING: if (sysRetire) state <= HALTED;
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (setup) begin
			regionQ <= region;
			errQ <= illegal;
			statusQ <= state;
		end
	end

	always_comb begin
		case (regionQ)
			REGION_IMEM: apbRsp.prdata = imemRdata;
			REGION_DMEM: apbRsp.prdata = dmemRdata;
			REGION_REGS: apbRsp.prdata = regRdata;
			REGION_CTRL: apbRsp.prdata = {30'd0, statusQ};
			default: apbRsp.prdata = 32'd0;
		endcase
		if (errQ) apbRsp.prdata = 32'd0;
		apbRsp.pready = apbReq.psel && apbReq.penable;
		apbRsp.pslverr = apbReq.psel && apbReq.penable && errQ;
	end

endmodule

// File: rtl/fetchStage.sv
`include "cpuSettings.svh"

module fetchStage import isaPkg::*, pipePkg::*; (
	input  logic        clk,
	input  logic        rstN,
	input  hostAccessT  imemAcc,
	output logic [31:0] imemRdata,
	input  logic        runStart,
	input  logic        running,
	input  logic        fetchHold,
	output ifIdT        ifId
);

	localparam int IAW = $clog2(`IMEM_DEPTH);

	logic [31:0] imem [`IMEM_DEPTH];
	logic [31:0] rdWord;
	logic [IAW-1:0] pc;
	logic [IAW-1:0] memAddr;
	logic fetchEn;
	logic valid;

	assign fetchEn = running && !fetchHold;
	assign memAddr = imemAcc.en ? imemAcc.addr[IAW-1:0] : pc;

	// Read register doubles as the IF/ID instruction and holds on a stall
	always_ff @(posedge clk) begin
		if (imemAcc.en && imemAcc.wr) imem[memAddr] <= imemAcc.wdata;
		if (imemAcc.en || fetchEn) rdWord <= imem[memAddr];
	end

	always_ff @(posedge clk) begin
		if (!rstN || runStart) begin
			pc <= '0;
			valid <= 1'b0;
		end else if (running) begin
			if (!fetchHold) begin
				pc <= pc + 1'b1;
				valid <= 1'b1;
			end
		end else begin
			valid <= 1'b0;
		end
	end

	assign imemRdata = rdWord;
	assign ifId.valid = valid;
	assign ifId.instr = instrT'(rdWord);

endmodule

// File: rtl/decodeStage.sv
module decodeStage import isaPkg::*, pipePkg::*; (
	input  logic        clk,
	input  logic        rstN,
	input  ifIdT        ifId,
	input  wbT          wb,
	input  hostAccessT  regAcc,
	output logic [31:0] regRdata,
	input  logic        runStart,
	output logic        fetchHold,
	output idExT        idEx
);

	logic [31:0] regs [32];
	instrT instr;
	logic usesRs;
	logic loadUse;
	logic sysSeen;
	logic issue;

	// Register 0 reads zero, a same-cycle write passes straight through
	function automatic logic [31:0] regRead(input logic [4:0] idx);
		if (idx == 5'd0) return 32'd0;
		if (wb.en && wb.dest == idx) return wb.value;
		return regs[idx];
	endfunction

	assign instr = ifId.instr;
	assign usesRs = instr.opcode != OP_LI;

	// LW in execute feeding the instruction in decode
	always_comb begin
		loadUse = ifId.valid && idEx.valid && idEx.instr.opcode == OP_LW &&
			idEx.instr.rt != 5'd0 &&
			((usesRs && instr.rs == idEx.instr.rt) ||
			(readsRt(instr) && instr.rt == idEx.instr.rt));
	end

	assign issue = ifId.valid && !sysSeen && !loadUse;
	assign fetchHold = loadUse || sysSeen;

	always_ff @(posedge clk) begin
		if (wb.en && wb.dest != 5'd0) regs[wb.dest] <= wb.value;
		if (regAcc.en) regRdata <= regRead(regAcc.addr[4:0]);
	end

	always_ff @(posedge clk) begin
		idEx.instr <= instr;
		idEx.opA <= regRead(instr.rs);
		idEx.opB <= readsRt(instr) ? regRead(instr.rt) : immOf(instr);
		if (!rstN || runStart) begin
			idEx.valid <= 1'b0;
			sysSeen <= 1'b0;
		end else begin
			idEx.valid <= issue;
			// Nothing younger than SYSCALL issues
			if (issue && isSyscall(instr)) sysSeen <= 1'b1;
		end
	end

endmodule

// File: rtl/executeStage.sv
`include "cpuSettings.svh"

module executeStage import isaPkg::*, pipePkg::*; (
	input  logic  clk,
	input  logic  rstN,
	input  idExT  idEx,
	input  wbT    wb,
	input  logic  runStart,
	output exMemT exMem
);

	localparam int DAW = $clog2(`DMEM_DEPTH);

	instrT instr;
	logic [31:0] fwdA;
	logic [31:0] fwdB;
	logic [31:0] addrSum;
	logic [31:0] result;

	// Newest producer wins
	function automatic logic [31:0] forward(input logic [4:0] idx, input logic [31:0] regVal);
		if (idx == 5'd0) return regVal;
		if (exMem.valid && writesReg(exMem.instr) && destReg(exMem.instr) == idx)
			return exMem.aluResult;
		if (wb.en && wb.dest == idx) return wb.value;
		return regVal;
	endfunction

	assign instr = idEx.instr;
	assign fwdA = forward(instr.rs, idEx.opA);
	// opB is the immediate when rt is a destination
	assign fwdB = readsRt(instr) ? forward(instr.rt, idEx.opB) : idEx.opB;
	assign addrSum = fwdA + immOf(instr);

	always_comb begin
		case (instr.opcode)
			OP_RTYPE: begin
				case (instr.func)
					FN_ADD: result = fwdA + fwdB;
					FN_SUB: result = fwdA - fwdB;
					FN_SLT: result = {31'd0, $signed(fwdA) < $signed(fwdB)};
					default: result = 32'd0;
				endcase
			end
			OP_XORI: result = fwdA ^ fwdB;
			OP_LI: result = fwdB;
			// Word address wraps inside data memory
			OP_LW, OP_SW: result = {{(32-DAW){1'b0}}, addrSum[DAW-1:0]};
			default: result = 32'd0;
		endcase
	end

	always_ff @(posedge clk) begin
		exMem.instr <= instr;
		exMem.aluResult <= result;
		exMem.storeData <= fwdB;
		if (!rstN || runStart) exMem.valid <= 1'b0;
		else exMem.valid <= idEx.valid;
	end

endmodule

// File: rtl/memoryStage.sv
`include "cpuSettings.svh"

module memoryStage import isaPkg::*, pipePkg::*; (
	input  logic        clk,
	input  logic        rstN,
	input  exMemT       exMem,
	input  hostAccessT  dmemAcc,
	output logic [31:0] dmemRdata,
	input  logic        runStart,
	output wbT          wb,
	output logic        sysRetire
);

	localparam int DAW = $clog2(`DMEM_DEPTH);

	logic [31:0] dmem [`DMEM_DEPTH];
	logic [31:0] rdWord;
	logic [DAW-1:0] memAddr;
	logic [31:0] memWdata;
	logic memWe;
	logic wbEn;
	logic wbSys;
	logic wbLoad;
	logic [4:0] wbDest;
	logic [31:0] wbAlu;

	// Host owns the port only while the core is stopped
	always_comb begin
		if (dmemAcc.en) begin
			memAddr = dmemAcc.addr[DAW-1:0];
			memWe = dmemAcc.wr;
			memWdata = dmemAcc.wdata;
		end else begin
			memAddr = exMem.aluResult[DAW-1:0];
			memWe = exMem.valid && exMem.instr.opcode == OP_SW;
			memWdata = exMem.storeData;
		end
	end

	always_ff @(posedge clk) begin
		if (memWe) dmem[memAddr] <= memWdata;
		rdWord <= dmem[memAddr];
	end

	always_ff @(posedge clk) begin
		wbLoad <= exMem.instr.opcode == OP_LW;
		wbDest <= destReg(exMem.instr);
		wbAlu <= exMem.aluResult;
		if (!rstN || runStart) begin
			wbEn <= 1'b0;
			wbSys <= 1'b0;
		end else begin
			wbEn <= exMem.valid && writesReg(exMem.instr);
			wbSys <= exMem.valid && isSyscall(exMem.instr);
		end
	end

	// Load data arrives straight from the memory read register
	assign wb.en = wbEn;
	assign wb.dest = wbDest;
	assign wb.value = wbLoad ? rdWord : wbAlu;
	assign sysRetire = wbSys;
	assign dmemRdata = rdWord;

endmodule

// File: rtl/cpuTop.sv
module cpuTop import pipePkg::*; (
	input  logic   clk,
	input  logic   rstN,
	input  apbReqT apbReq,
	output apbRspT apbRsp
);

	hostAccessT imemAcc;
	hostAccessT dmemAcc;
	hostAccessT regAcc;
	logic [31:0] imemRdata;
	logic [31:0] dmemRdata;
	logic [31:0] regRdata;
	logic sysRetire;
	logic runStart;
	logic running;
	logic fetchHold;
	ifIdT ifId;
	idExT idEx;
	exMemT exMem;
	wbT wb;

	hostPort host (
		.clk(clk), .rstN(rstN),
		.apbReq(apbReq), .apbRsp(apbRsp),
		.imemAcc(imemAcc), .dmemAcc(dmemAcc), .regAcc(regAcc),
		.imemRdata(imemRdata), .dmemRdata(dmemRdata), .regRdata(regRdata),
		.sysRetire(sysRetire), .runStart(runStart), .running(running)
	);

	fetchStage fetch (
		.clk(clk), .rstN(rstN),
		.imemAcc(imemAcc), .imemRdata(imemRdata),
		.runStart(runStart), .running(running), .fetchHold(fetchHold),
		.ifId(ifId)
	);

	decodeStage decode (
		.clk(clk), .rstN(rstN),
		.ifId(ifId), .wb(wb),
		.regAcc(regAcc), .regRdata(regRdata),
		.runStart(runStart), .fetchHold(fetchHold), .idEx(idEx)
	);

	executeStage execute (
		.clk(clk), .rstN(rstN),
		.idEx(idEx), .wb(wb), .runStart(runStart), .exMem(exMem)
	);

	memoryStage memory (
		.clk(clk), .rstN(rstN),
		.exMem(exMem), .dmemAcc(dmemAcc), .dmemRdata(dmemRdata),
		.runStart(runStart), .wb(wb), .sysRetire(sysRetire)
	);

endmodule

// File: testbench/clockGen.sv
module clockGen (
	output logic clk
);

	localparam int HALF_PERIOD = 50;

	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

endmodule

// File: testbench/cpuTb.sv
`include "cpuSettings.svh"

module cpuTb import isaPkg::*, pipePkg::*; ();

	localparam int DRIVE_DELAY = 10;
	localparam int SETTLE_DELAY = 10;
	localparam int APB_TIMEOUT = 20;
	localparam int RUN_TIMEOUT = 300;
	localparam logic [3:0] REGION_IMEM = 4'd0;
	localparam logic [3:0] REGION_DMEM = 4'd1;
	localparam logic [3:0] REGION_REGS = 4'd2;
	localparam logic [3:0] REGION_CTRL = 4'd3;

	logic clk;
	logic rstN;
	apbReqT apbReq;
	apbRspT apbRsp;

	logic [31:0] prog [$];
	logic [31:0] modelReg [32];
	logic [31:0] modelMem [`DMEM_DEPTH];
	int checks;
	int errors;

	clockGen clkGen (.clk(clk));

	cpuTop uut (.clk(clk), .rstN(rstN), .apbReq(apbReq), .apbRsp(apbRsp));

	task automatic finishRun();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	endtask

	task automatic timeoutAbort(input string what);
		$display("Timeout: %s did not complete in time", what);
		errors++;
		finishRun();
	endtask

	task automatic checkWord(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("ERROR %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic checkState(input string name, input runStateE exp, input runStateE act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("ERROR %s: expected %s, actual %s (%0d)", name, exp.name(), act.name(), act);
		end
	endtask

	task automatic checkErr(input string name, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("ERROR %s: expected pslverr %b, actual %b", name, exp, act);
		end
	endtask

	function automatic logic [15:0] regionAddr(input logic [3:0] region, input int word);
		return (16'(region) << `REGION_LSB) | 16'(word << 2);
	endfunction

	// Starts and ends a drive delay after a rising edge
	task automatic apbTransfer(input logic wr, input logic [15:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic err);
		int waitCycles;
		apbReq.psel = 1'b1;
		apbReq.penable = 1'b0;
		apbReq.pwrite = wr;
		apbReq.paddr = addr;
		apbReq.pwdata = wdata;
		@(posedge clk);
		#DRIVE_DELAY;
		apbReq.penable = 1'b1;
		#SETTLE_DELAY;
		waitCycles = 0;
		while (!apbRsp.pready) begin
			if (waitCycles == APB_TIMEOUT) timeoutAbort("APB transfer");
			waitCycles++;
			@(posedge clk);
			#(DRIVE_DELAY + SETTLE_DELAY);
		end
		rdata = apbRsp.prdata;
		err = apbRsp.pslverr;
		@(posedge clk);
		#DRIVE_DELAY;
		apbReq = '0;
	endtask

	task automatic apbWrite(input logic [15:0] addr, input logic [31:0] wdata, output logic err);
		logic [31:0] unused;
		apbTransfer(1'b1, addr, wdata, unused, err);
	endtask

	task automatic apbRead(input logic [15:0] addr, output logic [31:0] rdata, output logic err);
		apbTransfer(1'b0, addr, 32'd0, rdata, err);
	endtask

	function automatic logic [31:0] rInstr(input funcE fn, input logic [4:0] rs,
		input logic [4:0] rt, input logic [4:0] rd);
		return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic logic [31:0] iInstr(input opcodeE op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] randomAlu(input logic [4:0] rd, input logic [4:0] rs,
		input logic [4:0] rt);
		case ($urandom_range(4))
			0: return rInstr(FN_ADD, rs, rt, rd);
			1: return rInstr(FN_SUB, rs, rt, rd);
			2: return rInstr(FN_SLT, rs, rt, rd);
			3: return iInstr(OP_XORI, rs, rd, 16'($urandom));
			default: return iInstr(OP_LI, 5'd0, rd, 16'($urandom));
		endcase
	endfunction

	task automatic genInit();
		prog.delete();
		for (int r = 1; r < 32; r++) prog.push_back(iInstr(OP_LI, 5'd0, 5'(r), 16'($urandom)));
		prog.push_back(rInstr(FN_SYSCALL, 5'd0, 5'd0, 5'd0));
	endtask

	// Sources r1 to r15 are never written and destinations start at r16
	task automatic genIndependent(input int len);
		prog.delete();
		for (int i = 0; i < len; i++) begin
			prog.push_back(randomAlu(5'(16 + i % 16), 5'($urandom_range(15, 1)),
				5'($urandom_range(15, 1))));
		end
		prog.push_back(rInstr(FN_SYSCALL, 5'd0, 5'd0, 5'd0));
	endtask

	// Eight registers only so most instructions depend on recent ones
	task automatic genDependent(input int len);
		prog.delete();
		for (int i = 0; i < len; i++) begin
			prog.push_back(randomAlu(5'($urandom_range(7)), 5'($urandom_range(7)),
				5'($urandom_range(7))));
		end
		prog.push_back(rInstr(FN_SYSCALL, 5'd0, 5'd0, 5'd0));
	endtask

	task automatic genMemory(input int len);
		logic [4:0] rt;
		prog.delete();
		for (int i = 0; i < len; i++) begin
			rt = 5'($urandom_range(7));
			case ($urandom_range(2))
				0: begin
					prog.push_back(iInstr(OP_LW, 5'($urandom_range(7)), rt, 16'($urandom)));
					// Load-use pair
					if ($urandom_range(1) == 1) begin
						prog.push_back(rInstr(FN_ADD, rt, 5'($urandom_range(7)),
							5'($urandom_range(7))));
					end
				end
				1: prog.push_back(iInstr(OP_SW, 5'($urandom_range(7)), rt, 16'($urandom)));
				default: prog.push_back(randomAlu(rt, 5'($urandom_range(7)),
					5'($urandom_range(7))));
			endcase
		end
		prog.push_back(rInstr(FN_SYSCALL, 5'd0, 5'd0, 5'd0));
	endtask

	// Architectural interpreter running one instruction at a time up to SYSCALL
	task automatic runModel();
		logic [31:0] w;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm;
		logic [31:0] res;
		logic [4:0] dest;
		logic wr;
		int unsigned addr;
		for (int i = 0; i < prog.size(); i++) begin
			w = prog[i];
			a = modelReg[w[25:21]];
			b = modelReg[w[20:16]];
			imm = {{16{w[15]}}, w[15:0]};
			addr = (a + imm) % `DMEM_DEPTH;
			dest = w[20:16];
			wr = 1'b1;
			res = 32'd0;
			if (w[31:26] == OP_RTYPE && w[5:0] == FN_SYSCALL) return;
			case (w[31:26])
				OP_RTYPE: begin
					dest = w[15:11];
					if (w[5:0] == FN_ADD) res = a + b;
					else if (w[5:0] == FN_SUB) res = a - b;
					else res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
				end
				OP_LI: res = imm;
				OP_XORI: res = a ^ imm;
				OP_LW: res = modelMem[addr];
				default: begin
					modelMem[addr] = b;
					wr = 1'b0;
				end
			endcase
			if (wr && dest != 5'd0) modelReg[dest] = res;
		end
	endtask

	task automatic loadProgram(input string name);
		logic err;
		foreach (prog[i]) begin
			apbWrite(regionAddr(REGION_IMEM, i), prog[i], err);
			checkErr({name, " imem load"}, 1'b0, err);
		end
	endtask

	task automatic startRun(input string name);
		logic err;
		apbWrite(regionAddr(REGION_CTRL, 0), 32'd1, err);
		checkErr({name, " start"}, 1'b0, err);
	endtask

	task automatic waitHalted(input string name);
		logic [31:0] rdata;
		logic err;
		int polls;
		polls = 0;
		do begin
			if (polls == RUN_TIMEOUT) timeoutAbort({name, " program run"});
			polls++;
			apbRead(regionAddr(REGION_CTRL, 0), rdata, err);
		end while (rdata[1:0] == RUNNING);
		checkState({name, " status"}, HALTED, runStateE'(rdata[1:0]));
	endtask

	task automatic compareRegs(input string name);
		logic [31:0] rdata;
		logic err;
		for (int r = 0; r < 32; r++) begin
			apbRead(regionAddr(REGION_REGS, r), rdata, err);
			checkWord($sformatf("%s r%0d", name, r), modelReg[r], rdata);
		end
	endtask

	task automatic compareMem(input string name);
		logic [31:0] rdata;
		logic err;
		for (int i = 0; i < `DMEM_DEPTH; i++) begin
			apbRead(regionAddr(REGION_DMEM, i), rdata, err);
			checkWord($sformatf("%s dmem[%0d]", name, i), modelMem[i], rdata);
		end
	endtask

	task automatic runProgram(input string name, input logic withMem);
		loadProgram(name);
		runModel();
		startRun(name);
		waitHalted(name);
		compareRegs(name);
		if (withMem) compareMem(name);
	endtask

	initial begin
		logic [31:0] rdata;
		logic err;
		logic [31:0] imemWords [32];
		apbReq = '0;
		rstN = 1'b0;
		checks = 0;
		errors = 0;
		modelReg[0] = 32'd0;
		void'($urandom(33));
		repeat (8) @(posedge clk);
		#DRIVE_DELAY;
		rstN = 1'b1;

		apbRead(regionAddr(REGION_CTRL, 0), rdata, err);
		checkState("reset status", IDLE, runStateE'(rdata[1:0]));
		for (int i = 0; i < `DMEM_DEPTH; i++) begin
			modelMem[i] = $urandom;
			apbWrite(regionAddr(REGION_DMEM, i), modelMem[i], err);
			checkErr("dmem write", 1'b0, err);
		end
		compareMem("dmem readback");
		for (int i = 0; i < 32; i++) begin
			imemWords[i] = $urandom;
			apbWrite(regionAddr(REGION_IMEM, 100 + i), imemWords[i], err);
		end
		for (int i = 0; i < 32; i++) begin
			apbRead(regionAddr(REGION_IMEM, 100 + i), rdata, err);
			checkWord($sformatf("imem readback %0d", i), imemWords[i], rdata);
		end
		apbRead(regionAddr(REGION_CTRL, 0), rdata, err);
		checkState("idle status", IDLE, runStateE'(rdata[1:0]));

		// Register file holds no reset value
		genInit();
		runProgram("init", 1'b0);
		repeat (2) begin
			genIndependent(16);
			runProgram("independent", 1'b0);
		end
		repeat (4) begin
			genDependent(24);
			runProgram("dependent", 1'b0);
		end
		repeat (4) begin
			genMemory(24);
			runProgram("memory", 1'b1);
		end

		genDependent(40);
		loadProgram("busy");
		runModel();
		startRun("busy");
		apbRead(regionAddr(REGION_CTRL, 0), rdata, err);
		checkState("busy status", RUNNING, runStateE'(rdata[1:0]));
		apbWrite(regionAddr(REGION_DMEM, 3), ~modelMem[3], err);
		checkErr("busy dmem write", 1'b1, err);
		apbRead(regionAddr(REGION_DMEM, 3), rdata, err);
		checkErr("busy dmem read", 1'b1, err);
		apbWrite(regionAddr(REGION_IMEM, 5), 32'hffffffff, err);
		checkErr("busy imem write", 1'b1, err);
		apbWrite(regionAddr(REGION_REGS, 4), ~modelReg[4], err);
		checkErr("busy reg write", 1'b1, err);
		waitHalted("busy");
		apbWrite(regionAddr(REGION_REGS, 4), ~modelReg[4], err);
		checkErr("halted reg write", 1'b1, err);
		apbRead(regionAddr(REGION_IMEM, 5), rdata, err);
		checkWord("busy imem word", prog[5], rdata);
		compareRegs("busy");
		compareMem("busy");

		genMemory(30);
		runProgram("restart", 1'b1);
		finishRun();
	end

endmodule

// File: src.f
+incdir+rtl
rtl/isaPkg.sv
rtl/pipePkg.sv
rtl/hostPort.sv
rtl/fetchStage.sv
rtl/decodeStage.sv
rtl/executeStage.sv
rtl/memoryStage.sv
rtl/cpuTop.sv
testbench/clockGen.sv
testbench/cpuTb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module cpuTb -f src.f
out=$(./obj_dir/VcpuTb)
echo "$out"
echo "$out" | grep -qx "No errors"
